// ==== verilog/keypad_pkg.sv ====
package keypad_pkg;

  // 4x4 matrix keypad
  localparam int unsigned num_rows = 4;
  localparam int unsigned num_cols = 4;
  localparam int unsigned col_idx_w = $clog2(num_cols); // Column counter width

  // Identical full scans needed to accept a press or a release
  localparam int unsigned debounce_scans = 3;
  localparam int unsigned debounce_w = $clog2(debounce_scans + 1);
  localparam logic [debounce_w-1:0] debounce_max = debounce_w'(debounce_scans);

  // One-hot row and column, row 0 and column 0 in the top bit
  typedef struct packed {
    logic [num_rows-1:0] row;
    logic [num_cols-1:0] col;
  } key_code_t;

  // Inactive keys
  localparam key_code_t key_1 = '{row: 4'b1000, col: 4'b1000}; // R0 C0
  localparam key_code_t key_a = '{row: 4'b1000, col: 4'b0001}; // R0 C3
  localparam key_code_t key_b = '{row: 4'b0100, col: 4'b0001}; // R1 C3
  localparam key_code_t key_d = '{row: 4'b0001, col: 4'b0001}; // R3 C3

  // Letter keys with four letters
  localparam key_code_t key_7 = '{row: 4'b0010, col: 4'b1000}; // R2 C0, PQRS
  localparam key_code_t key_9 = '{row: 4'b0010, col: 4'b0010}; // R2 C2, WXYZ

  // Control keys
  localparam key_code_t submit_letter_key = '{row: 4'b0001, col: 4'b1000}; // R3 C0, '*'
  localparam key_code_t clear_key         = '{row: 4'b0001, col: 4'b0100}; // R3 C1, '0'
  localparam key_code_t submit_word_key   = '{row: 4'b0001, col: 4'b0010}; // R3 C2, '#'
  localparam key_code_t game_end_key      = '{row: 4'b0010, col: 4'b0001}; // R2 C3, 'C'

  // Tap position within the letter set of a key
  typedef enum logic [2:0] {
    init = 3'd0, // No letter in progress
    s0   = 3'd1, // First letter
    s1   = 3'd2,
    s2   = 3'd3,
    s3   = 3'd4, // Only for keys 7 and 9
    done = 3'd5  // Letter confirmed
  } tap_state_t;

endpackage

// ==== verilog/text_pkg.sv ====
package text_pkg;

  // One character, upper-case ASCII
  typedef logic [7:0] ascii_t;

  // Word buffer capacity in letters
  localparam int unsigned word_len = 5;
  localparam int unsigned count_w = $clog2(word_len + 1); // Holds 0 to word_len
  localparam logic [count_w-1:0] word_full = count_w'(word_len);

  // Confirmed letters, slot 0 holds the first letter
  typedef struct packed {
    ascii_t [word_len-1:0] chars;
    logic [count_w-1:0]    count; // Letters stored
  } word_t;

endpackage

// ==== verilog/keypad_scanner.sv ====
`timescale 1ns/1ps

module keypad_scanner import keypad_pkg::*; (
  input  logic                clk,
  input  logic                nRst,
  input  logic [num_rows-1:0] rows,   // Active-high row returns
  output logic [num_cols-1:0] cols,   // One-hot column select
  output logic                strobe, // One pulse per accepted press
  output key_code_t           key     // Valid while strobe is high
);
  logic [col_idx_w-1:0] col_idx;
  logic                 scan_end; // Last column of a full scan

  // Key gathered over the current scan
  key_code_t acc, acc_next;
  logic      acc_valid, acc_valid_next;
  logic      acc_multi, acc_multi_next; // More than one key seen

  key_code_t             scan_key;   // Result of a complete scan, 0 if none
  key_code_t             last_scan;
  logic [debounce_w-1:0] match_cnt, match_cnt_next;
  logic                  stable;     // Enough identical scans in a row
  logic                  pressed;    // A press has been reported
  logic                  press_fire;

  // Column 0 sits in the top bit
  assign cols = {1'b1, {(num_cols - 1){1'b0}}} >> col_idx;
  assign scan_end = (col_idx == col_idx_w'(num_cols - 1));

  always_comb begin
    acc_next = acc;
    acc_valid_next = acc_valid;
    acc_multi_next = acc_multi;
    if (rows != '0) begin
      if (acc_valid || !$onehot(rows)) begin
        acc_multi_next = 1'b1; // Two keys at once count as none
      end else begin
        acc_next.row = rows;
        acc_next.col = cols;
        acc_valid_next = 1'b1;
      end
    end
    scan_key = (acc_valid_next && !acc_multi_next) ? acc_next : '0;

    // Count identical scans, saturating at the threshold
    if (scan_key == last_scan)
      match_cnt_next = (match_cnt == debounce_max) ? match_cnt : match_cnt + 1'b1;
    else
      match_cnt_next = debounce_w'(1);
    stable = (match_cnt_next == debounce_max);
  end

  assign press_fire = scan_end && stable && (scan_key != '0) && !pressed;

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      col_idx   <= '0;
      acc       <= '0;
      acc_valid <= 1'b0;
      acc_multi <= 1'b0;
      last_scan <= '0;
      match_cnt <= '0;
      pressed   <= 1'b0;
      strobe    <= 1'b0;
    end else begin
      col_idx <= col_idx + 1'b1; // Wraps after the last column
      strobe  <= press_fire;
      if (scan_end) begin
        acc       <= '0; // Fresh start for the next scan
        acc_valid <= 1'b0;
        acc_multi <= 1'b0;
        last_scan <= scan_key;
        match_cnt <= match_cnt_next;
        if (press_fire)
          pressed <= 1'b1;
        else if (stable && scan_key == '0)
          pressed <= 1'b0; // Debounced release
      end else begin
        acc       <= acc_next;
        acc_valid <= acc_valid_next;
        acc_multi <= acc_multi_next;
      end
    end
  end

  // Key code held until the next press
  always_ff @(posedge clk) begin
    if (press_fire)
      key <= scan_key;
  end

endmodule

// ==== verilog/ascii_encoder.sv ====
`timescale 1ns/1ps

module ascii_encoder import keypad_pkg::*, text_pkg::*; (
  input  logic [num_rows-1:0] row,
  input  logic [num_cols-1:0] col,
  input  tap_state_t          tap,
  output ascii_t              ascii_character // 0 when there is no letter
);
  key_code_t  code;
  ascii_t     base;     // First letter of the set
  logic       four;     // Set has four letters
  logic [1:0] offset;   // Position within the set
  logic       in_range;

  assign code = '{row: row, col: col};

  // Phone letter sets, 2 ABC through 9 WXYZ
  always_comb begin
    base = '0;
    four = 1'b0;
    case (code)
      8'b1000_0100: base = "A"; // Key 2
      8'b1000_0010: base = "D"; // Key 3
      8'b0100_1000: base = "G"; // Key 4
      8'b0100_0100: base = "J"; // Key 5
      8'b0100_0010: base = "M"; // Key 6
      key_7: begin
        base = "P";
        four = 1'b1;
      end
      8'b0010_0100: base = "T"; // Key 8
      key_9: begin
        base = "W";
        four = 1'b1;
      end
      default: base = '0; // Controls and inactive keys
    endcase
  end

  always_comb begin
    offset = 2'd0;
    in_range = 1'b1;
    case (tap)
      s0: offset = 2'd0;
      s1: offset = 2'd1;
      s2: offset = 2'd2;
      s3: begin
        offset = 2'd3;
        in_range = four; // Fourth letter on 7 and 9 only
      end
      default: in_range = 1'b0; // No letter in init or done
    endcase
  end

  assign ascii_character = (base != '0 && in_range) ? base + ascii_t'(offset) : '0;

endmodule

// ==== verilog/keypad_fsm.sv ====
`timescale 1ns/1ps

module keypad_fsm import keypad_pkg::*, text_pkg::*; (
  input  logic      clk,
  input  logic      nRst,
  input  logic      strobe,      // One pulse per key press
  input  key_code_t cur_key,     // Row and column of the press
  output logic      ready,       // Letter confirmed, high in done
  output logic      game_end,    // Game end key pulse
  output logic      invalid_key, // Inactive key pulse
  output ascii_t    data         // Letter preview
);
  tap_state_t state, next_state;
  key_code_t  prev_key;         // Last key that was not inactive
  logic       unlocked;         // prev_key may be matched
  logic       next_unlocked;
  ascii_t     letter, next_data;

  logic is_inactive;
  logic is_cancel;
  logic is_submit;
  logic is_repeat;
  logic is_four;

  // Letter for the tap state being entered
  ascii_encoder encoder (
    .row             (cur_key.row),
    .col             (cur_key.col),
    .tap             (next_state),
    .ascii_character (letter)
  );

  assign is_inactive = (cur_key == key_1) || (cur_key == key_a) || (cur_key == key_b) ||
                       (cur_key == key_d) || (cur_key == submit_word_key);
  assign is_cancel = (cur_key == clear_key) || (cur_key == game_end_key);
  assign is_submit = (cur_key == submit_letter_key);
  assign is_repeat = unlocked && (prev_key == cur_key); // Same key again
  assign is_four   = (cur_key == key_7) || (cur_key == key_9);

  // Pulses in the strobe cycle
  assign invalid_key = strobe && is_inactive;
  assign game_end    = strobe && (cur_key == game_end_key);

  always_comb begin
    next_state = state;
    next_data = data;
    next_unlocked = unlocked;
    if (strobe) begin
      if (is_inactive) begin
        next_unlocked = 1'b0; // Next letter press starts over
      end else begin
        next_unlocked = 1'b1;
        if (is_cancel) begin
          // Clear and game end drop the letter in progress
          next_state = init;
          next_data = '0;
        end else if (is_submit) begin
          if (state == done) begin
            next_state = init; // Second submit closes the letter
            next_data = '0;
          end else if (state != init) begin
            next_state = done; // Data already holds the letter
          end
        end else begin
          if (is_repeat) begin
            case (state)
              s0:      next_state = s1;
              s1:      next_state = s2;
              s2:      next_state = is_four ? s3 : s0;
              default: next_state = s0; // s3 wraps
            endcase
          end else begin
            next_state = s0; // New letter set
          end
          next_data = letter;
        end
      end
    end
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      state    <= init;
      ready    <= 1'b0;
      data     <= '0;
      unlocked <= 1'b0;
      prev_key <= '0;
    end else begin
      state    <= next_state;
      ready    <= (next_state == done);
      data     <= next_data;
      unlocked <= next_unlocked;
      if (strobe && !is_inactive)
        prev_key <= cur_key; // Inactive keys leave the letter key in place
    end
  end

endmodule

// ==== verilog/word_builder.sv ====
`timescale 1ns/1ps

module word_builder import text_pkg::*; (
  input  logic   clk,
  input  logic   nRst,
  input  logic   ready,    // Letter confirmed level
  input  ascii_t letter,   // Letter to store
  input  logic   game_end, // Empties the word
  output word_t  word
);
  logic ready_q; // Ready one cycle back
  logic ready_rise;
  logic has_room;

  assign ready_rise = ready && !ready_q;
  assign has_room   = (word.count < word_full);

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= ready;
    end
  end

  // Game end wins over an append in the same cycle
  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      word <= '0;
    end else if (game_end) begin
      word <= '0;
    end else if (ready_rise && has_room) begin
      word.chars[word.count] <= letter; // Next free slot
      word.count <= word.count + 1'b1;
    end
  end

endmodule

// ==== verilog/keypad_text_top.sv ====
`timescale 1ns/1ps

module keypad_text_top import keypad_pkg::*, text_pkg::*; (
  input  logic                clk,
  input  logic                nRst,
  input  logic [num_rows-1:0] rows,        // Keypad row returns
  output logic [num_cols-1:0] cols,        // Keypad column drive
  output ascii_t              data,        // Letter preview
  output logic                ready,       // Letter confirmed
  output logic                game_end,
  output logic                invalid_key,
  output word_t               word         // Confirmed letters
);
  logic      strobe;
  key_code_t key;

  // Matrix scan and debounce
  keypad_scanner scanner (
    .clk    (clk),
    .nRst   (nRst),
    .rows   (rows),
    .cols   (cols),
    .strobe (strobe),
    .key    (key)
  );

  // Multi-tap letter selection
  keypad_fsm fsm (
    .clk         (clk),
    .nRst        (nRst),
    .strobe      (strobe),
    .cur_key     (key),
    .ready       (ready),
    .game_end    (game_end),
    .invalid_key (invalid_key),
    .data        (data)
  );

  // Word collection
  word_builder builder (
    .clk      (clk),
    .nRst     (nRst),
    .ready    (ready),
    .letter   (data),
    .game_end (game_end),
    .word     (word)
  );

endmodule

// ==== testbench/keypad_text_chk.sv ====
`timescale 1ns/1ps

module keypad_text_chk import keypad_pkg::*, text_pkg::*; (
  input logic               clk,
  input logic               nRst,
  input tap_state_t         state,       // FSM tap state
  input logic               ready,
  input logic               game_end,
  input logic               invalid_key,
  input logic [count_w-1:0] count        // Word builder letter count
);
  int unsigned failures = 0; // Polled by the testbench

  // Ready only rises out of a letter in progress
  a_ready_rise: assert property (@(posedge clk) disable iff (!nRst)
                                 $rose(ready) |-> ($past(state) != init) &&
                                                  ($past(state) != done))
    else begin
      $error("ready rose without a letter in progress");
      failures++;
    end

  a_game_end_pulse: assert property (@(posedge clk) disable iff (!nRst) game_end |=> !game_end)
    else begin
      $error("game_end held for two cycles");
      failures++;
    end

  a_invalid_pulse: assert property (@(posedge clk) disable iff (!nRst)
                                    invalid_key |=> !invalid_key)
    else begin
      $error("invalid_key held for two cycles");
      failures++;
    end

  a_count_range: assert property (@(posedge clk) disable iff (!nRst) count <= word_len)
    else begin
      $error("word count above capacity");
      failures++;
    end

endmodule

// Sees the FSM and the word builder from the top level
bind keypad_text_top keypad_text_chk i_chk (
  .clk         (clk),
  .nRst        (nRst),
  .state       (fsm.state),
  .ready       (ready),
  .game_end    (game_end),
  .invalid_key (invalid_key),
  .count       (word.count)
);

// ==== testbench/keypad_text_tb.sv ====
`timescale 1ns/1ps

module keypad_text_tb import keypad_pkg::*, text_pkg::*; ();
  localparam int unsigned clk_period = 40;
  localparam int unsigned scan_cycles = num_cols * debounce_scans; // Cycles of one debounce
  localparam int unsigned wait_limit = 4 * scan_cycles;            // Timeout of every wait
  localparam int unsigned num_steps = 38;

  // Letter keys not named in the package, standard phone layout
  localparam key_code_t key_2 = '{row: 4'b1000, col: 4'b0100};
  localparam key_code_t key_3 = '{row: 4'b1000, col: 4'b0010};
  localparam key_code_t key_4 = '{row: 4'b0100, col: 4'b1000};
  localparam key_code_t key_5 = '{row: 4'b0100, col: 4'b0100};
  localparam key_code_t key_6 = '{row: 4'b0100, col: 4'b0010};
  localparam key_code_t key_8 = '{row: 4'b0010, col: 4'b0100};

  typedef struct packed {
    key_code_t          key;
    ascii_t             data;
    logic               ready;
    logic               game_end;    // Pulse in the strobe cycle
    logic               invalid_key; // Pulse in the strobe cycle
    logic [count_w-1:0] count;
    ascii_t             last;        // Last stored letter, 0 when empty
  } step_t;

  step_t steps [num_steps] = '{
    '{key_2,             "A", 1'b0, 1'b0, 1'b0, 3'd0, 8'h00}, // Key 2 cycles A B C A
    '{key_2,             "B", 1'b0, 1'b0, 1'b0, 3'd0, 8'h00},
    '{key_2,             "C", 1'b0, 1'b0, 1'b0, 3'd0, 8'h00},
    '{key_2,             "A", 1'b0, 1'b0, 1'b0, 3'd0, 8'h00},
    '{key_7,             "P", 1'b0, 1'b0, 1'b0, 3'd0, 8'h00}, // Four letters on 7
    '{key_7,             "Q", 1'b0, 1'b0, 1'b0, 3'd0, 8'h00},
    '{key_7,             "R", 1'b0, 1'b0, 1'b0, 3'd0, 8'h00},
    '{key_7,             "S", 1'b0, 1'b0, 1'b0, 3'd0, 8'h00},
    '{key_7,             "P", 1'b0, 1'b0, 1'b0, 3'd0, 8'h00},
    '{key_2,             "A", 1'b0, 1'b0, 1'b0, 3'd0, 8'h00}, // New key restarts
    '{key_2,             "B", 1'b0, 1'b0, 1'b0, 3'd0, 8'h00},
    '{key_3,             "D", 1'b0, 1'b0, 1'b0, 3'd0, 8'h00},
    '{submit_letter_key, "D", 1'b1, 1'b0, 1'b0, 3'd1, "D"},   // Confirm and store
    '{submit_letter_key, 8'h00, 1'b0, 1'b0, 1'b0, 3'd1, "D"}, // Close the letter
    '{key_9,             "W", 1'b0, 1'b0, 1'b0, 3'd1, "D"},
    '{key_9,             "X", 1'b0, 1'b0, 1'b0, 3'd1, "D"},
    '{key_1,             "X", 1'b0, 1'b0, 1'b1, 3'd1, "D"},   // Inactive, locks repeat
    '{key_9,             "W", 1'b0, 1'b0, 1'b0, 3'd1, "D"},
    '{key_a,             "W", 1'b0, 1'b0, 1'b1, 3'd1, "D"},
    '{key_b,             "W", 1'b0, 1'b0, 1'b1, 3'd1, "D"},
    '{key_d,             "W", 1'b0, 1'b0, 1'b1, 3'd1, "D"},
    '{submit_word_key,   "W", 1'b0, 1'b0, 1'b1, 3'd1, "D"},
    '{key_9,             "W", 1'b0, 1'b0, 1'b0, 3'd1, "D"},
    '{clear_key,         8'h00, 1'b0, 1'b0, 1'b0, 3'd1, "D"}, // Word untouched
    '{key_4,             "G", 1'b0, 1'b0, 1'b0, 3'd1, "D"},
    '{game_end_key,      8'h00, 1'b0, 1'b1, 1'b0, 3'd0, 8'h00}, // Word emptied
    '{key_4,             "G", 1'b0, 1'b0, 1'b0, 3'd0, 8'h00}, // Fill the word
    '{submit_letter_key, "G", 1'b1, 1'b0, 1'b0, 3'd1, "G"},
    '{key_5,             "J", 1'b0, 1'b0, 1'b0, 3'd1, "G"},
    '{submit_letter_key, "J", 1'b1, 1'b0, 1'b0, 3'd2, "J"},
    '{key_6,             "M", 1'b0, 1'b0, 1'b0, 3'd2, "J"},
    '{submit_letter_key, "M", 1'b1, 1'b0, 1'b0, 3'd3, "M"},
    '{key_8,             "T", 1'b0, 1'b0, 1'b0, 3'd3, "M"},
    '{submit_letter_key, "T", 1'b1, 1'b0, 1'b0, 3'd4, "T"},
    '{key_2,             "A", 1'b0, 1'b0, 1'b0, 3'd4, "T"},
    '{submit_letter_key, "A", 1'b1, 1'b0, 1'b0, 3'd5, "A"},
    '{key_3,             "D", 1'b0, 1'b0, 1'b0, 3'd5, "A"},
    '{submit_letter_key, "D", 1'b1, 1'b0, 1'b0, 3'd5, "A"}   // Sixth letter dropped
  };

  logic                clk;
  logic                nRst;
  logic [num_rows-1:0] rows = '0;
  logic [num_cols-1:0] cols;
  ascii_t              data;
  logic                ready;
  logic                game_end;
  logic                invalid_key;
  word_t               word;
  key_code_t           held_key = '0;   // Key pressed on the model keypad
  logic [31:0]         lfsr = 32'h5d09;

  keypad_text_top i_dut (
    .clk         (clk),
    .nRst        (nRst),
    .rows        (rows),
    .cols        (cols),
    .data        (data),
    .ready       (ready),
    .game_end    (game_end),
    .invalid_key (invalid_key),
    .word        (word)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Keypad model, row of the held key returns while its column is driven
  always @(negedge clk) begin
    rows <= ((held_key.col & cols) != '0) ? held_key.row : '0;
  end

  always @(negedge clk) begin
    if (i_dut.i_chk.failures != 0)
      fail_stop("an assertion in the checker failed");
  end

  task automatic fail_stop(input string reason);
    $display("%s", reason);
    $display("Some tests failed");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] expected);
    if (got !== expected)
      fail_stop($sformatf("error at %0t ns: %s is %0h, expected %0h",
                          $time, name, got, expected));
  endtask

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  task automatic random_bits(input int unsigned nbits, output int unsigned value);
    int unsigned b;
    value = 0;
    for (b = 0; b < nbits; b++) begin
      value = (value << 1) | int'(lfsr[0]); // One step per bit taken
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic apply_step(input int unsigned idx);
    step_t       s;
    int unsigned hold_extra;
    int unsigned gap_extra;
    int unsigned waited;
    ascii_t      last;
    s = steps[idx];
    random_bits(3, hold_extra);
    random_bits(3, gap_extra);
    held_key <= s.key;
    waited = 0;
    @(negedge clk);
    while (!i_dut.strobe && waited < wait_limit) begin // Scan phase sets the latency
      waited++;
      @(negedge clk);
    end
    if (!i_dut.strobe)
      fail_stop($sformatf("step %0d: the key press gave no strobe in time", idx));
    check_value($sformatf("game_end (step %0d)", idx), 64'(game_end), 64'(s.game_end));
    check_value($sformatf("invalid_key (step %0d)", idx), 64'(invalid_key), 64'(s.invalid_key));
    repeat (2) @(negedge clk); // Data one cycle after the strobe, word one more
    last = (word.count == '0) ? 8'h00 : word.chars[word.count - 1'b1];
    check_value($sformatf("data (step %0d)", idx), 64'(data), 64'(s.data));
    check_value($sformatf("ready (step %0d)", idx), 64'(ready), 64'(s.ready));
    check_value($sformatf("word.count (step %0d)", idx), 64'(word.count), 64'(s.count));
    check_value($sformatf("last letter (step %0d)", idx), 64'(last), 64'(s.last));
    repeat (hold_extra) @(negedge clk);
    held_key <= '0;
    waited = 0;
    while ((i_dut.scanner.pressed || waited < scan_cycles) && waited < wait_limit) begin
      waited++;
      @(negedge clk);
    end
    if (i_dut.scanner.pressed)
      fail_stop($sformatf("step %0d: the key release was not seen in time", idx));
    repeat (gap_extra) @(negedge clk);
  endtask

  task automatic check_full_word();
    string       expected;
    int unsigned i;
    expected = "GJMTA"; // First five submitted letters
    for (i = 0; i < word_len; i++)
      check_value($sformatf("word.chars[%0d]", i), 64'(word.chars[i]), 64'(expected[i]));
  endtask

  initial begin
    nRst = 1'b0;
    repeat (3) @(negedge clk);
    check_value("cols", 64'(cols), 64'(4'b1000)); // Column 0 after reset
    check_value("data", 64'(data), 64'(0));
    check_value("ready", 64'(ready), 64'(0));
    check_value("game_end", 64'(game_end), 64'(0));
    check_value("invalid_key", 64'(invalid_key), 64'(0));
    check_value("word.count", 64'(word.count), 64'(0));
    nRst = 1'b1;
    for (int unsigned i = 0; i < num_steps; i++)
      apply_step(i);
    check_full_word();
    $display("All tests passed");
    $finish;
  end

endmodule

// ==== build.f ====
verilog/keypad_pkg.sv
verilog/text_pkg.sv
verilog/keypad_scanner.sv
verilog/ascii_encoder.sv
verilog/keypad_fsm.sv
verilog/word_builder.sv
verilog/keypad_text_top.sv
testbench/keypad_text_chk.sv
testbench/keypad_text_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the keypad text testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module keypad_text_tb \
  --Mdir obj_dir -o keypad_text_sim \
  -f build.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Assertion errors must not stop the run before the testbench reports them
./obj_dir/keypad_text_sim +verilator+error+limit+10 > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -q "Some tests failed" "$log_file"; then
  echo "Simulation FAILED"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
echo "Simulation PASSED"
exit 0
